/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = heapTb
FILELIST  = verilog.f
LOG       = sim.log
FAIL      = Done: errors found

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* rtl/arrayAllocator.sv */
/*
 * Array allocator
 * Hands out array numbers, reusing freed ones last-in first-out,
 * and decides whether the commanded array is live
 */
`timescale 1ns/1ps

module arrayAllocator import heapPkg::*; #(
  parameter int ADDRESS_BITS = 2               // Array number width
) (
  input  logic      clock,
  input  logic      reset,
  heapCmdIf.sink    cmd,                       // Command stream
  allocIf.provider  alloc                      // Status to the store
);
  localparam int ARRAYS = 2 ** ADDRESS_BITS;   // Arrays in the heap

  logic [ADDRESS_BITS-1:0] freeStack [ARRAYS]; // Freed array numbers
  logic [ADDRESS_BITS:0]   stackTop;           // Entries on the stack
  logic [ADDRESS_BITS:0]   allocCount;         // Numbers ever handed out
  logic [ARRAYS-1:0]       allocated;          // Live flag per array
  logic [ADDRESS_BITS-1:0] topSlot;            // Next free stack slot
  logic [ADDRESS_BITS-1:0] popSlot;            // Most recent entry
  logic                    isAlloc;
  logic                    isFree;

  assign isAlloc = cmd.strobe && cmd.action == actAlloc;
  assign isFree  = cmd.strobe && cmd.action == actFree;
  assign topSlot = stackTop[ADDRESS_BITS-1:0];
  assign popSlot = topSlot - 1'b1;             // Wraps right when stack is full

  //----------------------------------------------------------------------
  // Liveness and alloc/free outcome
  //----------------------------------------------------------------------
  always_comb begin
    if ({1'b0, cmd.array} >= allocCount) alloc.liveError = errNotAllocated;
    else if (!allocated[cmd.array])      alloc.liveError = errFreed;
    else                                 alloc.liveError = errNone;
  end

  always_comb begin
    alloc.grant      = 1'b0;
    alloc.allocError = errNone;
    alloc.newArray   = '0;
    if (isAlloc) begin
      if (stackTop != '0) begin                // Reuse latest freed array
        alloc.grant    = 1'b1;
        alloc.newArray = freeStack[popSlot];
      end else if (allocCount < ARRAYS) begin  // Fresh number
        alloc.grant    = 1'b1;
        alloc.newArray = allocCount[ADDRESS_BITS-1:0];
      end else begin
        alloc.allocError = errOutOfMemory;
      end
    end else if (isFree) begin
      if (alloc.liveError == errNone) alloc.grant = 1'b1;
      else alloc.allocError = alloc.liveError; // Catches double free
    end
  end

  //----------------------------------------------------------------------
  // State update
  //----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      stackTop   <= '0;
      allocCount <= '0;
      allocated  <= '0;
    end else if (alloc.grant) begin
      if (isAlloc) begin
        allocated[alloc.newArray] <= 1'b1;
        if (stackTop != '0) stackTop <= stackTop - 1'b1;
        else allocCount <= allocCount + 1'b1;
      end else begin                           // Granted free
        allocated[cmd.array] <= 1'b0;
        stackTop             <= stackTop + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc.grant && isFree) freeStack[topSlot] <= cmd.array;
  end

endmodule

/* rtl/arrayStore.sv */
/*
 * Array store
 * Element memory and size table, per-command checks and the registered response
 */
`timescale 1ns/1ps

module arrayStore import heapPkg::*; #(
  parameter int ADDRESS_BITS = 2,              // Array number width
  parameter int INDEX_BITS   = 2,              // Element index width
  parameter int DATA_BITS    = 12              // Element width
) (
  input  logic                 clock,
  input  logic                 reset,
  heapCmdIf.sink               cmd,            // Command stream
  allocIf.consumer             alloc,          // Allocator status
  output logic [DATA_BITS-1:0] dataOut,        // Response data
  output heapError             error,          // Response outcome
  output logic                 done            // Response valid
);
  localparam int ARRAYS   = 2 ** ADDRESS_BITS;
  localparam int CAPACITY = 2 ** INDEX_BITS;   // Elements per array

  logic [DATA_BITS-1:0]             memory [ARRAYS*CAPACITY];  // Flat, {array, index}
  logic [INDEX_BITS:0]              sizeTable [ARRAYS];        // 0 .. CAPACITY
  logic [ADDRESS_BITS+INDEX_BITS-1:0] slot;
  logic [INDEX_BITS:0]              size;
  logic [INDEX_BITS:0]              indexWide;
  logic [INDEX_BITS-1:0]            lastIndex; // Index of the end element
  logic [DATA_BITS-1:0]             element;
  logic [DATA_BITS-1:0]             lastElement;
  logic [DATA_BITS-1:0]             aluUpdated;
  logic [DATA_BITS-1:0]             aluResult;

  // Next state and response
  logic                             writeEnable;
  logic [ADDRESS_BITS+INDEX_BITS-1:0] writeSlot;
  logic [DATA_BITS-1:0]             writeData;
  logic                             sizeEnable;
  logic [ADDRESS_BITS-1:0]          sizeArray;
  logic [INDEX_BITS:0]              sizeValue;
  heapError                         nextError;
  logic [DATA_BITS-1:0]             nextData;

  assign slot        = {cmd.array, cmd.index};
  assign size        = sizeTable[cmd.array];
  assign indexWide   = {1'b0, cmd.index};
  assign lastIndex   = size[INDEX_BITS-1:0] - 1'b1;
  assign element     = memory[slot];
  assign lastElement = memory[{cmd.array, lastIndex}];

  elementAlu #(.DATA_BITS(DATA_BITS)) alu (
    .action  (cmd.action),
    .current (element),
    .operand (cmd.dataIn),
    .updated (aluUpdated),
    .result  (aluResult)
  );

  //----------------------------------------------------------------------
  // Command decode and checks
  //----------------------------------------------------------------------
  always_comb begin
    writeEnable = 1'b0;
    writeSlot   = slot;
    writeData   = cmd.dataIn;
    sizeEnable  = 1'b0;
    sizeArray   = cmd.array;
    sizeValue   = size;
    nextError   = errNone;
    nextData    = '0;
    if (cmd.action == actAlloc) begin
      nextError = alloc.allocError;
      if (alloc.grant) begin                   // New array starts empty
        sizeEnable = 1'b1;
        sizeArray  = alloc.newArray;
        sizeValue  = '0;
        nextData   = DATA_BITS'(alloc.newArray);
      end
    end else if (cmd.action == actFree) begin
      nextError = alloc.allocError;
    end else if (alloc.liveError != errNone) begin
      nextError = alloc.liveError;             // Liveness checked first
    end else begin
      case (cmd.action)
        actWrite: begin
          writeEnable = 1'b1;
          nextData    = cmd.dataIn;
          if (indexWide >= size) begin         // Writing past the end grows it
            sizeEnable = 1'b1;
            sizeValue  = indexWide + 1'b1;
          end
        end
        actRead: begin
          if (indexWide >= size) nextError = errOutOfBounds;
          else nextData = element;
        end
        actSize: nextData = DATA_BITS'(size);
        actPush: begin
          if (size == CAPACITY) nextError = errFull;
          else begin
            writeEnable = 1'b1;
            writeSlot   = {cmd.array, size[INDEX_BITS-1:0]};
            sizeEnable  = 1'b1;
            sizeValue   = size + 1'b1;
            nextData    = cmd.dataIn;
          end
        end
        actPop: begin
          if (size == '0) nextError = errEmpty;
          else begin
            sizeEnable = 1'b1;
            sizeValue  = size - 1'b1;
            nextData   = lastElement;
          end
        end
        actResize: begin
          if (cmd.dataIn > CAPACITY) nextError = errTooLarge;
          else begin
            sizeEnable = 1'b1;
            sizeValue  = cmd.dataIn[INDEX_BITS:0];
            nextData   = cmd.dataIn;
          end
        end
        actAdd, actAddAfter, actSub, actSubAfter, actAnd, actOr, actXor, actNot: begin
          if (indexWide >= size) nextError = errOutOfBounds;
          else begin
            writeEnable = 1'b1;
            writeData   = aluUpdated;
            nextData    = aluResult;
          end
        end
        default: nextError = errBadAction;
      endcase
    end
  end

  //----------------------------------------------------------------------
  // Storage and response registers
  //----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (cmd.strobe && writeEnable) memory[writeSlot]    <= writeData;
    if (cmd.strobe && sizeEnable)  sizeTable[sizeArray] <= sizeValue;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      done    <= 1'b0;
      error   <= errNone;
      dataOut <= '0;
    end else begin
      done <= cmd.strobe;                      // One cycle per command
      if (cmd.strobe) begin                    // Hold until next response
        error   <= nextError;
        dataOut <= nextData;
      end
    end
  end

endmodule

/* rtl/elementAlu.sv */
/*
 * Element ALU
 * New value and returned value of an in-place element update
 */
`timescale 1ns/1ps

module elementAlu import heapPkg::*; #(
  parameter int DATA_BITS = 12                 // Element width
) (
  input  heapAction            action,         // In-place operation
  input  logic [DATA_BITS-1:0] current,        // Element before update
  input  logic [DATA_BITS-1:0] operand,        // Command data word
  output logic [DATA_BITS-1:0] updated,        // Element after update
  output logic [DATA_BITS-1:0] result          // Value to report
);

  always_comb begin
    case (action)
      actAdd, actAddAfter: updated = current + operand;  // Wraps
      actSub, actSubAfter: updated = current - operand;  // Wraps
      actAnd:              updated = current & operand;
      actOr:               updated = current | operand;
      actXor:              updated = current ^ operand;
      actNot:              updated = ~current;
      default:             updated = current;            // Not an in-place op
    endcase
  end

  // The "after" forms hand back the old value
  assign result = (action == actAddAfter || action == actSubAfter) ? current : updated;

endmodule

/* rtl/heapIf.sv */
/*
 * Heap interfaces
 * Command bus from the top level, and allocation status from allocator to store
 */
`timescale 1ns/1ps

interface heapCmdIf import heapPkg::*; #(
  parameter int ADDRESS_BITS = 2,              // Array number width
  parameter int INDEX_BITS   = 2,              // Element index width
  parameter int DATA_BITS    = 12              // Element width
);
  logic                    strobe;             // One command this cycle
  heapAction               action;             // What to do
  logic [ADDRESS_BITS-1:0] array;              // Target array
  logic [INDEX_BITS-1:0]   index;              // Element within array
  logic [DATA_BITS-1:0]    dataIn;             // Operand or value

  modport source (output strobe, action, array, index, dataIn);
  modport sink   (input  strobe, action, array, index, dataIn);
endinterface

interface allocIf import heapPkg::*; #(
  parameter int ADDRESS_BITS = 2               // Array number width
);
  heapError                liveError;          // Liveness of commanded array
  logic                    grant;              // Alloc or free went through
  heapError                allocError;         // Outcome of alloc or free
  logic [ADDRESS_BITS-1:0] newArray;           // Number handed out

  modport provider (output liveError, grant, allocError, newArray);
  modport consumer (input  liveError, grant, allocError, newArray);
endinterface

/* rtl/heapPkg.sv */
/*
 * Heap command set
 * Action codes and command outcomes shared by the heap RTL and its testbench
 */
package heapPkg;

  //----------------------------------------------------------------------
  // Command codes
  //----------------------------------------------------------------------
  typedef enum logic [4:0] {
    actWrite    = 5'd2,                        // Write an element
    actRead     = 5'd3,                        // Read an element
    actSize     = 5'd4,                        // Size of an array
    actPush     = 5'd14,                       // Append at the end
    actPop      = 5'd15,                       // Remove from the end
    actResize   = 5'd17,                       // Set the size
    actAlloc    = 5'd18,                       // Hand out an array
    actFree     = 5'd19,                       // Give an array back
    actAdd      = 5'd20,                       // Add, return new value
    actAddAfter = 5'd21,                       // Add, return old value
    actSub      = 5'd22,                       // Subtract, return new value
    actSubAfter = 5'd23,                       // Subtract, return old value
    actNot      = 5'd27,                       // Bitwise invert
    actOr       = 5'd28,                       // Or with operand
    actXor      = 5'd29,                       // Xor with operand
    actAnd      = 5'd30                        // And with operand
  } heapAction;

  //----------------------------------------------------------------------
  // Command outcomes
  //----------------------------------------------------------------------
  typedef enum logic [3:0] {
    errNone         = 4'd0,                    // Command succeeded
    errNotAllocated = 4'd1,                    // Array never handed out
    errFreed        = 4'd2,                    // Array currently free
    errOutOfBounds  = 4'd3,                    // Index not below size
    errFull         = 4'd4,                    // Push at capacity
    errEmpty        = 4'd5,                    // Pop of empty array
    errOutOfMemory  = 4'd6,                    // No array left
    errTooLarge     = 4'd7,                    // Resize beyond capacity
    errBadAction    = 4'd8                     // Unknown command code
  } heapError;

endpackage

/* rtl/heapTop.sv */
/*
 * Heap top level
 * Plain command ports onto the command bus, allocator and array store
 */
`timescale 1ns/1ps

module heapTop import heapPkg::*; #(
  parameter int ADDRESS_BITS = 2,              // Array number width
  parameter int INDEX_BITS   = 2,              // Capacity is 2**INDEX_BITS
  parameter int DATA_BITS    = 12              // Element width
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    strobe,      // Command valid
  input  heapAction               action,
  input  logic [ADDRESS_BITS-1:0] array,
  input  logic [INDEX_BITS-1:0]   index,
  input  logic [DATA_BITS-1:0]    dataIn,
  output logic [DATA_BITS-1:0]    dataOut,
  output heapError                error,
  output logic                    done         // High the cycle after strobe
);

  heapCmdIf #(
    .ADDRESS_BITS (ADDRESS_BITS),
    .INDEX_BITS   (INDEX_BITS),
    .DATA_BITS    (DATA_BITS)
  ) cmd ();
  allocIf #(.ADDRESS_BITS(ADDRESS_BITS)) alloc ();

  assign cmd.strobe = strobe;
  assign cmd.action = action;
  assign cmd.array  = array;
  assign cmd.index  = index;
  assign cmd.dataIn = dataIn;

  arrayAllocator #(.ADDRESS_BITS(ADDRESS_BITS)) allocator (
    .clock (clock),
    .reset (reset),
    .cmd   (cmd),
    .alloc (alloc)
  );

  arrayStore #(
    .ADDRESS_BITS (ADDRESS_BITS),
    .INDEX_BITS   (INDEX_BITS),
    .DATA_BITS    (DATA_BITS)
  ) store (
    .clock   (clock),
    .reset   (reset),
    .cmd     (cmd),
    .alloc   (alloc),
    .dataOut (dataOut),
    .error   (error),
    .done    (done)
  );

endmodule

/* tb/heapTb.sv */
/*
 * Heap testbench
 * Drives command sequences into the heap, predicts each response with a
 * reference model and checks done, dataOut and error one cycle after each strobe
 */
`timescale 1ns/1ps

module heapTb import heapPkg::*; ();
  localparam int DATA_BITS      = 12;
  localparam int ARRAYS         = 4;
  localparam int CAPACITY       = 4;
  localparam int RESET_CYCLES   = 5;
  localparam int TOTAL_COMMANDS = 88;                  // Sum over the six tests
  localparam int CYCLE_LIMIT    = 2 * TOTAL_COMMANDS + RESET_CYCLES;

  logic                 clock = 1'b0;
  logic                 reset;
  logic                 strobe;
  heapAction            action;
  logic [1:0]           array;
  logic [1:0]           index;
  logic [DATA_BITS-1:0] dataIn;
  logic [DATA_BITS-1:0] dataOut;
  heapError             error;
  logic                 done;

  // Reference copy of the heap state
  bit                   refLive [ARRAYS];
  int                   refCount;
  int                   refStack [$];                  // Freed numbers in LIFO order
  int                   refSize [ARRAYS];
  logic [DATA_BITS-1:0] refMem [ARRAYS][CAPACITY];

  // One pending response per strobe
  int                   dueQueue [$];                  // Cycle the response is due
  logic [DATA_BITS-1:0] dataQueue [$];
  heapError             errorQueue [$];

  int                   cycleCount;
  int                   errorCount;
  int                   testCount;
  int                   testStartErrors;
  logic [31:0]          lcgState;
  logic                 expectDone;
  logic [DATA_BITS-1:0] wantData;
  heapError             wantError;
  heapAction            inPlaceOps [8] = '{actAdd, actAddAfter, actSub, actSubAfter,
                                           actAnd, actOr, actXor, actNot};

  heapTop UUT (
    .clock (clock), .reset (reset), .strobe (strobe), .action (action),
    .array (array), .index (index), .dataIn (dataIn),
    .dataOut (dataOut), .error (error), .done (done)
  );

  initial begin
    forever #4 clock = ~clock;                         // 8 ns period
  end

  always @(posedge clock) cycleCount <= cycleCount + 1;

  function automatic logic [15:0] nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[31:16];                            // Upper bits are the better ones
  endfunction

  //----------------------------------------------------------------------
  // Reference model stepping one command per call
  //----------------------------------------------------------------------
  function automatic void modelStep(input heapAction act, input int arr, input int idx,
                                    input logic [DATA_BITS-1:0] data,
                                    output logic [DATA_BITS-1:0] expData,
                                    output heapError expErr);
    heapError             live;
    logic [DATA_BITS-1:0] old;
    logic [DATA_BITS-1:0] upd;
    int                   newArr;
    expData = '0;
    expErr  = errNone;
    if (arr >= refCount) live = errNotAllocated;
    else if (!refLive[arr]) live = errFreed;
    else live = errNone;
    if (act == actAlloc) begin
      newArr = -1;
      if (refStack.size() > 0) newArr = refStack.pop_back();  // Latest freed first
      else if (refCount < ARRAYS) begin
        newArr = refCount;
        refCount++;
      end
      if (newArr < 0) expErr = errOutOfMemory;
      else begin
        refLive[newArr] = 1'b1;
        refSize[newArr] = 0;
        expData         = DATA_BITS'(newArr);
      end
    end else if (act == actFree) begin
      if (live != errNone) expErr = live;
      else begin
        refLive[arr] = 1'b0;
        refStack.push_back(arr);
      end
    end else if (live != errNone) begin
      expErr = live;
    end else begin
      case (act)
        actWrite: begin
          refMem[arr][idx] = data;
          if (idx >= refSize[arr]) refSize[arr] = idx + 1;
          expData = data;
        end
        actRead: begin
          if (idx >= refSize[arr]) expErr = errOutOfBounds;
          else expData = refMem[arr][idx];
        end
        actSize: expData = DATA_BITS'(refSize[arr]);
        actPush: begin
          if (refSize[arr] == CAPACITY) expErr = errFull;
          else begin
            refMem[arr][refSize[arr]] = data;
            refSize[arr]++;
            expData = data;
          end
        end
        actPop: begin
          if (refSize[arr] == 0) expErr = errEmpty;
          else begin
            refSize[arr]--;
            expData = refMem[arr][refSize[arr]];
          end
        end
        actResize: begin
          if (int'(data) > CAPACITY) expErr = errTooLarge;
          else begin
            refSize[arr] = int'(data);
            expData      = data;
          end
        end
        actAdd, actAddAfter, actSub, actSubAfter, actAnd, actOr, actXor, actNot: begin
          if (idx >= refSize[arr]) expErr = errOutOfBounds;
          else begin
            old = refMem[arr][idx];
            case (act)
              actAdd, actAddAfter: upd = old + data;    // Wraps at 12 bits
              actSub, actSubAfter: upd = old - data;
              actAnd:              upd = old & data;
              actOr:               upd = old | data;
              actXor:              upd = old ^ data;
              default:             upd = ~old;
            endcase
            refMem[arr][idx] = upd;
            expData = (act == actAddAfter || act == actSubAfter) ? old : upd;
          end
        end
        default: expErr = errBadAction;
      endcase
    end
  endfunction

  //----------------------------------------------------------------------
  // Stimulus helpers
  //----------------------------------------------------------------------
  task automatic sendCommand(input heapAction act, input int arr, input int idx,
                             input logic [DATA_BITS-1:0] data);
    logic [DATA_BITS-1:0] expData;
    heapError             expErr;
    @(negedge clock);
    strobe = 1'b1;
    action = act;
    array  = 2'(arr);
    index  = 2'(idx);
    dataIn = data;
    modelStep(act, arr, idx, data, expData, expErr);
    dueQueue.push_back(cycleCount + 1);                // Response one cycle later
    dataQueue.push_back(expData);
    errorQueue.push_back(expErr);
  endtask

  task automatic finishTest(input string name);
    @(negedge clock);
    strobe = 1'b0;
    while (dueQueue.size() != 0) @(negedge clock);     // Drain pending responses
    testCount++;
    $display("Test %0d %s: %0d errors", testCount, name, errorCount - testStartErrors);
    testStartErrors = errorCount;
  endtask

  //----------------------------------------------------------------------
  // Response comparison on the falling edge where outputs are stable
  //----------------------------------------------------------------------
  always @(negedge clock) begin
    expectDone = (dueQueue.size() != 0) && (dueQueue[0] == cycleCount);
    if (done !== expectDone) begin
      $display("ERROR at %0t: done expected %0b, got %0b", $time, expectDone, done);
      errorCount++;
    end
    if (expectDone) begin
      void'(dueQueue.pop_front());
      wantData  = dataQueue.pop_front();
      wantError = errorQueue.pop_front();
      if (dataOut !== wantData) begin
        $display("ERROR at %0t: dataOut expected %h, got %h", $time, wantData, dataOut);
        errorCount++;
      end
      if (error !== wantError) begin
        $display("ERROR at %0t: error expected %s, got %s", $time, wantError.name(),
                 error.name());
        errorCount++;
      end
    end
  end

  initial begin
    while (cycleCount < CYCLE_LIMIT) @(posedge clock);
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Done: errors found");
    $finish;
  end

  //----------------------------------------------------------------------
  // Test sequence
  //----------------------------------------------------------------------
  initial begin
    int          i;
    logic [15:0] rnd;
    reset  = 1'b1;
    strobe = 1'b0;
    action = actSize;
    array  = '0;
    index  = '0;
    dataIn = '0;
    cycleCount      = 0;
    errorCount      = 0;
    testCount       = 0;
    testStartErrors = 0;
    lcgState        = 32'd80;                          // Seed
    refCount        = 0;
    for (i = 0; i < ARRAYS; i++) begin
      refLive[i] = 1'b0;
      refSize[i] = 0;
    end
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    sendCommand(actRead, 0, 0, '0);                    // Not handed out yet
    for (i = 0; i < ARRAYS + 1; i++) sendCommand(actAlloc, 0, 0, '0);  // Fifth runs out
    for (i = 0; i < ARRAYS; i++) sendCommand(actSize, i, 0, '0);
    finishTest("allocation");

    sendCommand(actWrite, 2, 2, DATA_BITS'(nextRandom()));
    sendCommand(actSize, 2, 0, '0);
    sendCommand(actWrite, 2, 0, DATA_BITS'(nextRandom()));
    sendCommand(actWrite, 2, 1, DATA_BITS'(nextRandom()));
    for (i = 0; i < CAPACITY; i++) sendCommand(actRead, 2, i, '0);  // Last is out of bounds
    finishTest("write read size");

    sendCommand(actPush, 0, 0, 12'd1);
    sendCommand(actPush, 0, 0, 12'd2);
    for (i = 0; i < 3; i++) sendCommand(actPop, 0, 0, '0);  // Third pop finds it empty
    for (i = 0; i < CAPACITY + 1; i++) sendCommand(actPush, 0, 0, DATA_BITS'(nextRandom()));
    finishTest("push pop");

    sendCommand(actFree, 1, 0, '0);
    sendCommand(actFree, 3, 0, '0);
    sendCommand(actAlloc, 0, 0, '0);                   // Expect 3 back first
    sendCommand(actAlloc, 0, 0, '0);
    sendCommand(actFree, 1, 0, '0);
    sendCommand(actFree, 1, 0, '0);                    // Double free
    sendCommand(actRead, 1, 0, '0);
    sendCommand(actAlloc, 0, 0, '0);
    finishTest("free and reuse");

    for (i = 0; i < CAPACITY; i++) sendCommand(actPush, 1, 0, DATA_BITS'(nextRandom()));
    sendCommand(actWrite, 2, 0, 12'hFFF);
    sendCommand(actAddAfter, 2, 0, 12'd2);             // Wraps to 1
    sendCommand(actRead, 2, 0, '0);
    for (i = 0; i < 40; i++) begin
      rnd = nextRandom();
      sendCommand(inPlaceOps[rnd[2:0]], int'(rnd[3]), int'(rnd[5:4]), DATA_BITS'(nextRandom()));
    end
    finishTest("in-place operations");

    sendCommand(actResize, 3, 0, 12'(CAPACITY + 1));
    sendCommand(actSize, 3, 0, '0);
    sendCommand(actResize, 2, 0, 12'd2);
    sendCommand(actSize, 2, 0, '0);
    sendCommand(heapAction'(5'd0), 2, 0, '0);          // Unused code
    finishTest("resize and bad action");

    $display("Tests: %0d, errors: %0d", testCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* tb/heapTop_chk.sv */
/*
 * Heap protocol checker
 * Response timing and error rules, bound onto the heap top level
 */
`timescale 1ns/1ps

module heapTop_chk import heapPkg::*; #(
  parameter int DATA_BITS = 12                 // Element width
) (
  input logic                 clock,
  input logic                 reset,
  input logic                 strobe,
  input logic                 done,
  input heapError             error,
  input logic [DATA_BITS-1:0] dataOut
);

  // One response per strobe, exactly one cycle later
  doneFollowsStrobe: assert property (@(posedge clock)
    !reset && !$past(reset) |-> done == $past(strobe))
    else $error("done does not follow the previous strobe");

  doneLowAfterReset: assert property (@(posedge clock) $past(reset) && !reset |-> !done)
    else $error("done high right after reset");

  // Failed commands return no data
  errorClearsData: assert property (@(posedge clock) disable iff (reset)
    error != errNone |-> dataOut == '0)
    else $error("dataOut not zero on an error response");

endmodule

bind heapTop heapTop_chk #(.DATA_BITS(DATA_BITS)) protocolCheck (
  .clock (clock), .reset (reset), .strobe (strobe),
  .done (done), .error (error), .dataOut (dataOut)
);

/* verilog.f */
rtl/heapPkg.sv
rtl/heapIf.sv
rtl/arrayAllocator.sv
rtl/elementAlu.sv
rtl/arrayStore.sv
rtl/heapTop.sv
tb/heapTop_chk.sv
tb/heapTb.sv
